/* source/frv_defs.svh */
// --------------------------------------------------------------------------
// Core width macros shared by the package and the RTL of the memory stage.
// Include this file in any unit that sizes data, address or strobe fields.
// --------------------------------------------------------------------------

`ifndef FRV_DEFS_SVH
`define FRV_DEFS_SVH

// --------------------------------------------------------------------------
// Data path
// --------------------------------------------------------------------------

// Data and address width of the core
`define FRV_XLEN 32

// Byte lanes in one data word, one strobe bit each
`define FRV_STRB_W (`FRV_XLEN / 8)

`endif

/* source/frv_pkg.sv */
// --------------------------------------------------------------------------
// Shared types and constants of the pipeline. Stage payloads, forwarding
// and memory request bundles travel as the packed structs defined here.
// --------------------------------------------------------------------------

`default_nettype none

`include "frv_defs.svh"

package frv_pkg;

    // ----------------------------------------------------------------------
    // Functional unit positions in the one-hot fu field
    // ----------------------------------------------------------------------
    localparam int unsigned P_FU_ALU = 0; // Integer ALU
    localparam int unsigned P_FU_MUL = 1; // Multiply / divide
    localparam int unsigned P_FU_CFU = 2; // Control flow
    localparam int unsigned P_FU_LSU = 3; // Load / store
    localparam int unsigned P_FU_CSR = 4; // CSR access

    // ----------------------------------------------------------------------
    // LSU micro-op layout
    // ----------------------------------------------------------------------
    localparam int unsigned LSU_SIGNED   = 0; // Sign extend load data
    localparam int unsigned LSU_WIDTH_LO = 1; // Width field low bit
    localparam int unsigned LSU_WIDTH_HI = 2; // Width field high bit
    localparam int unsigned LSU_LOAD     = 3;
    localparam int unsigned LSU_STORE    = 4;

    localparam logic [1:0] LSU_BYTE = 2'd1; // Width codes
    localparam logic [1:0] LSU_HALF = 2'd2;
    localparam logic [1:0] LSU_WORD = 2'd3;

    // Trap causes raised in this stage
    localparam logic [5:0] TRAP_LDALIGN = 6'd4; // Load address misaligned
    localparam logic [5:0] TRAP_STALIGN = 6'd6; // Store address misaligned

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [4:0]           rd;    // Destination register
        logic [`FRV_XLEN-1:0] opr_a; // Operand A
        logic [`FRV_XLEN-1:0] opr_b; // Operand B
        logic [4:0]           uop;   // Micro-op code
        logic [4:0]           fu;    // One-hot functional unit
        logic                 trap;  // Raise a trap
        logic [1:0]           size;  // Instruction size
        logic [31:0]          instr; // Instruction word
    } s3_pkt_t;

    typedef s3_pkt_t s4_pkt_t; // Same layout toward writeback

    typedef struct packed {
        logic [4:0]           rd;    // Destination in stage 3
        logic [`FRV_XLEN-1:0] wdata; // Value to forward
        logic                 load;  // Result not ready yet
        logic                 csr;   // CSR op in flight
    } fwd_t;

    typedef struct packed {
        logic                   wen;   // Write enable
        logic [`FRV_STRB_W-1:0] strb;  // Byte lane strobe
        logic [`FRV_XLEN-1:0]   wdata; // Lane replicated data
        logic [`FRV_XLEN-1:0]   addr;  // Word aligned address
    } dmem_req_t;

endpackage

`default_nettype wire

/* source/frv_lsu.sv */
// --------------------------------------------------------------------------
// Load/store unit of the memory stage. Checks alignment, forms strobe and
// write data, and keeps one request on the data port until it is granted.
// The granted flag holds off a second request until the stage progresses.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "frv_defs.svh"

module frv_lsu (
    input  wire                       g_clk,        // Global clock
    input  wire                       g_resetn,     // Sync reset, active low
    input  wire                       flush,        // Stage flush
    input  wire                       lsu_valid,    // LSU op present
    output logic                      lsu_a_error,  // Misaligned access
    output logic                      lsu_ready,    // Op complete
    input  wire                       pipe_prog,    // Stage progressing
    input  wire [`FRV_XLEN-1:0]       lsu_addr,     // Byte address
    input  wire [`FRV_XLEN-1:0]       lsu_wdata,    // Store data
    input  wire                       lsu_load,     // Load op
    input  wire                       lsu_store,    // Store op
    input  wire                       lsu_byte,     // Byte width
    input  wire                       lsu_half,     // Halfword width
    input  wire                       lsu_signed,   // Signed load
    input  wire                       hold_lsu_req, // Withhold requests
    output logic                      dmem_req,     // Request valid
    output frv_pkg::dmem_req_t        dmem,         // Request fields
    input  wire                       dmem_gnt      // Request accepted
);

    logic                   lsu_word;   // Neither byte nor half
    logic                   misaligned; // Address breaks width rule
    logic                   req_done;   // Transfer completes now
    logic                   granted;    // Grant seen, waiting on stage
    logic [`FRV_STRB_W-1:0] strb;       // Lane strobe
    logic [`FRV_XLEN-1:0]   wdata;      // Replicated write data

    // ----------------------------------------------------------------------
    // Alignment and request control
    // ----------------------------------------------------------------------
    assign lsu_word   = !lsu_byte && !lsu_half;
    assign misaligned = (lsu_half && lsu_addr[0]) ||
                        (lsu_word && (lsu_addr[1:0] != 2'b00));

    assign lsu_a_error = lsu_valid && misaligned; // Trap, no request

    assign dmem_req = lsu_valid && !misaligned && !granted && !hold_lsu_req;
    assign req_done = dmem_req && dmem_gnt;

    assign lsu_ready = lsu_a_error || granted || req_done;

    // Cleared on progress so the next op can request
    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            granted <= 1'b0;
        end else if (pipe_prog) begin
            granted <= 1'b0;
        end else if (req_done) begin
            granted <= 1'b1;               // Stage 4 still busy
        end
    end

    // ----------------------------------------------------------------------
    // Strobe and write data lanes
    // ----------------------------------------------------------------------
    always_comb begin
        if (lsu_byte) begin
            strb  = 4'b0001 << lsu_addr[1:0];
            wdata = {4{lsu_wdata[7:0]}};   // Byte on every lane
        end else if (lsu_half) begin
            strb  = lsu_addr[1] ? 4'b1100 : 4'b0011;
            wdata = {2{lsu_wdata[15:0]}};  // Half on both halves
        end else begin
            strb  = 4'b1111;
            wdata = lsu_wdata;
        end
    end

    always_comb begin
        dmem.wen   = lsu_store;
        dmem.strb  = strb;
        dmem.wdata = wdata;
        dmem.addr  = {lsu_addr[`FRV_XLEN-1:2], 2'b00}; // Word aligned
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // Request stays put until granted, unless withheld by hold
    a_req_stable : assert property (
        @(posedge g_clk) disable iff (!g_resetn || flush)
        (dmem_req && !dmem_gnt) |=> (hold_lsu_req || (dmem_req && $stable(dmem)))
    );

    // Exactly one of load or store, signed only on loads
    a_op_decode : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        lsu_valid |-> ((lsu_load != lsu_store) && (!lsu_signed || lsu_load))
    );

endmodule

`default_nettype wire

/* source/frv_pipeline_register.sv */
// --------------------------------------------------------------------------
// One-entry register between two pipeline stages. Upstream pushes with
// i_valid while o_busy is low, downstream pops when it drops i_busy.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_register (
    input  wire              g_clk,    // Global clock
    input  wire              g_resetn, // Sync reset, active low
    input  wire              flush,    // Empty the register
    input  wire frv_pkg::s4_pkt_t i_data, // Payload from stage N
    input  wire              i_valid,  // Payload valid
    output logic             o_busy,   // Cannot take a new item
    output frv_pkg::s4_pkt_t o_data,   // Payload to stage N+1
    output logic             o_valid,  // Held item valid
    input  wire              i_busy    // Stage N+1 stalled
);

    logic capture; // Item taken on this edge

    // ----------------------------------------------------------------------
    // Flow control
    // ----------------------------------------------------------------------
    assign o_busy  = o_valid && i_busy;   // Full and not drained
    assign capture = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            o_valid <= 1'b0;
        end else if (capture) begin
            o_valid <= 1'b1;               // Replace or refill
        end else if (!i_busy) begin
            o_valid <= 1'b0;               // Drained, nothing new
        end
    end

    // Payload, no reset needed behind o_valid
    always_ff @(posedge g_clk) begin
        if (capture) begin
            o_data <= i_data;
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // Held item must not change under back-pressure
    a_hold_stable : assert property (
        @(posedge g_clk) disable iff (!g_resetn || flush)
        (o_valid && i_busy) |=> $stable(o_data)
    );

endmodule

`default_nettype wire

/* source/frv_pipeline_memory.sv */
// --------------------------------------------------------------------------
// Memory stage of the pipeline. Takes an instruction from stage 3, issues
// the data memory request of loads and stores, traps misaligned accesses,
// forwards its destination and passes the result on to stage 4.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "frv_defs.svh"

module frv_pipeline_memory (
    input  wire                g_clk,        // Global clock
    input  wire                g_resetn,     // Sync reset, active low
    input  wire                flush,        // Flush this stage
    input  wire frv_pkg::s3_pkt_t s3_pkt,    // Instruction from stage 3
    input  wire                s3_valid,     // Stage 3 packet valid
    output logic               s3_busy,      // Stage cannot accept
    output frv_pkg::fwd_t      fwd,          // Hazard forwarding
    input  wire                hold_lsu_req, // Withhold memory requests
    output logic               dmem_req,     // Memory request
    output frv_pkg::dmem_req_t dmem,         // Request fields
    input  wire                dmem_gnt,     // Request accepted
    output frv_pkg::s4_pkt_t   s4_pkt,       // Instruction to stage 4
    output logic               s4_valid,     // Stage 4 packet valid
    input  wire                s4_busy       // Stage 4 stalled
);

    import frv_pkg::*;

    logic       fu_lsu;
    logic       fu_csr;
    logic       lsu_valid;   // LSU op present
    logic       lsu_load;
    logic       lsu_store;
    logic       lsu_byte;
    logic       lsu_half;
    logic       lsu_signed;
    logic       lsu_a_error; // Misaligned access
    logic       lsu_ready;   // LSU op done
    logic [5:0] lsu_cause;   // Alignment trap cause
    logic       p_busy;      // Register full and stalled
    logic       pipe_prog;   // Instruction accepted this cycle
    s4_pkt_t    n_s4_pkt;    // Next stage 4 value

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------
    assign fu_lsu     = s3_pkt.fu[P_FU_LSU];
    assign fu_csr     = s3_pkt.fu[P_FU_CSR];
    assign lsu_valid  = s3_valid && fu_lsu;
    assign lsu_load   = s3_pkt.uop[LSU_LOAD];
    assign lsu_store  = s3_pkt.uop[LSU_STORE];
    assign lsu_byte   = s3_pkt.uop[LSU_WIDTH_HI:LSU_WIDTH_LO] == LSU_BYTE;
    assign lsu_half   = s3_pkt.uop[LSU_WIDTH_HI:LSU_WIDTH_LO] == LSU_HALF;
    assign lsu_signed = s3_pkt.uop[LSU_SIGNED];

    // Stall on a full register or an ungranted access
    assign s3_busy   = p_busy || (lsu_valid && !lsu_ready);
    assign pipe_prog = s3_valid && !s3_busy;

    assign lsu_cause = lsu_load ? TRAP_LDALIGN : TRAP_STALIGN;

    // ----------------------------------------------------------------------
    // Next stage value
    // ----------------------------------------------------------------------
    always_comb begin
        n_s4_pkt = s3_pkt;
        if (fu_lsu) begin
            n_s4_pkt.opr_a = {{(`FRV_XLEN-`FRV_STRB_W){1'b0}}, dmem.strb};
            n_s4_pkt.opr_b = s3_pkt.opr_a;  // Byte address for writeback
        end
        if (!s3_pkt.trap && lsu_a_error) begin
            n_s4_pkt.trap = 1'b1;
            n_s4_pkt.rd   = lsu_cause[4:0]; // Cause rides in rd
        end
    end

    // Forwarding straight from the stage 3 packet
    assign fwd.rd    = s3_pkt.rd;
    assign fwd.wdata = s3_pkt.opr_a;
    assign fwd.load  = fu_lsu && lsu_load;  // Data only after writeback
    assign fwd.csr   = fu_csr;

    // ----------------------------------------------------------------------
    // Submodules
    // ----------------------------------------------------------------------
    frv_lsu lsu_i (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .flush        (flush),
        .lsu_valid    (lsu_valid),
        .lsu_a_error  (lsu_a_error),
        .lsu_ready    (lsu_ready),
        .pipe_prog    (pipe_prog),
        .lsu_addr     (s3_pkt.opr_a),     // Address in operand A
        .lsu_wdata    (s3_pkt.opr_b),     // Store data in operand B
        .lsu_load     (lsu_load),
        .lsu_store    (lsu_store),
        .lsu_byte     (lsu_byte),
        .lsu_half     (lsu_half),
        .lsu_signed   (lsu_signed),
        .hold_lsu_req (hold_lsu_req),
        .dmem_req     (dmem_req),
        .dmem         (dmem),
        .dmem_gnt     (dmem_gnt)
    );

    frv_pipeline_register pipe_reg_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .flush    (flush),
        .i_data   (n_s4_pkt),
        .i_valid  (pipe_prog),
        .o_busy   (p_busy),
        .o_data   (s4_pkt),
        .o_valid  (s4_valid),
        .i_busy   (s4_busy)
    );

    // Hold from the core must block the port
    a_hold_blocks_req : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        hold_lsu_req |-> !dmem_req
    );

endmodule

`default_nettype wire

/* test/tb_frv_pipeline_memory.sv */
// --------------------------------------------------------------------------
// Testbench for the memory stage. Reads instruction cases from a data file,
// plays stage 3, the data memory and stage 4, and checks the memory port,
// forwarding and the stage 4 packets against the expected values.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_frv_pipeline_memory;

    import frv_pkg::*;

    localparam int N_FIELDS  = 19;  // Tokens per case line
    localparam int MAX_CASES = 64;
    localparam int CASE_CYC  = 200; // Watchdog budget per case

    // Token positions within one case line
    localparam int F_FU     = 0;
    localparam int F_UOP    = 1;
    localparam int F_OPA    = 2;
    localparam int F_OPB    = 3;
    localparam int F_RD     = 4;
    localparam int F_TRAP   = 5;
    localparam int F_GDLY   = 6;
    localparam int F_BUSY   = 7;
    localparam int F_HOLD   = 8;
    localparam int F_REQ    = 9;
    localparam int F_WEN    = 10;
    localparam int F_STRB   = 11;
    localparam int F_WDATA  = 12;
    localparam int F_ADDR   = 13;
    localparam int F_S4RD   = 14;
    localparam int F_S4A    = 15;
    localparam int F_S4B    = 16;
    localparam int F_S4TRAP = 17;
    localparam int F_FWDL   = 18;

    logic       g_clk;
    logic       g_resetn;
    logic       flush;
    s3_pkt_t    s3_pkt;
    logic       s3_valid;
    logic       s3_busy;
    fwd_t       fwd;
    logic       hold_lsu_req;
    logic       dmem_req;
    dmem_req_t  dmem;
    logic       dmem_gnt;
    s4_pkt_t    s4_pkt;
    logic       s4_valid;
    logic       s4_busy;

    logic [31:0] case_mem [0:N_FIELDS*MAX_CASES-1]; // Flat token array
    int          n_cases;
    int          retired;       // Packets taken by stage 4
    integer      seed;
    logic        loaded;
    s4_pkt_t     exp_pkt_q[$];  // Accepted, in order
    int          exp_busy_q[$]; // Stall length per packet

    frv_pipeline_memory dut_i (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .flush        (flush),
        .s3_pkt       (s3_pkt),
        .s3_valid     (s3_valid),
        .s3_busy      (s3_busy),
        .fwd          (fwd),
        .hold_lsu_req (hold_lsu_req),
        .dmem_req     (dmem_req),
        .dmem         (dmem),
        .dmem_gnt     (dmem_gnt),
        .s4_pkt       (s4_pkt),
        .s4_valid     (s4_valid),
        .s4_busy      (s4_busy)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;   // 100 MHz
    end

    // ----------------------------------------------------------------------
    // Reporting helpers
    // ----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    // ff in a delay column asks for a random length 0..7
    function automatic int pick_delay(input logic [31:0] raw);
        if (raw == 32'hff) begin
            return int'($unsigned($random(seed)) % 32'd8);
        end
        return int'(raw);
    endfunction

    // ----------------------------------------------------------------------
    // Stage 3 and memory side, one instruction
    // ----------------------------------------------------------------------
    task automatic run_case(input int c);
        int        b;
        int        gnt_wait;  // Cycles before the grant
        int        hold_left; // Cycles of hold still to go
        int        grants;
        int        cyc;
        bit        seen_req;
        bit        done;
        logic      exp_req;
        dmem_req_t first_req; // Request as first seen
        s4_pkt_t   exp_pkt;

        b            = c * N_FIELDS;
        s3_pkt.rd    = case_mem[b+F_RD][4:0];
        s3_pkt.opr_a = case_mem[b+F_OPA];
        s3_pkt.opr_b = case_mem[b+F_OPB];
        s3_pkt.uop   = case_mem[b+F_UOP][4:0];
        s3_pkt.fu    = case_mem[b+F_FU][4:0];
        s3_pkt.trap  = case_mem[b+F_TRAP][0];
        s3_pkt.size  = 2'b11;
        s3_pkt.instr = 32'h00000013 | (32'(c) << 7); // Tags the case

        exp_pkt       = s3_pkt;                      // Untouched fields pass
        exp_pkt.rd    = case_mem[b+F_S4RD][4:0];
        exp_pkt.opr_a = case_mem[b+F_S4A];
        exp_pkt.opr_b = case_mem[b+F_S4B];
        exp_pkt.trap  = case_mem[b+F_S4TRAP][0];
        exp_req       = case_mem[b+F_REQ][0];

        s3_valid     = 1'b1;
        hold_left    = int'(case_mem[b+F_HOLD]);
        hold_lsu_req = (hold_left > 0);
        dmem_gnt     = 1'b0;
        gnt_wait     = pick_delay(case_mem[b+F_GDLY]);
        grants       = 0;
        seen_req     = 1'b0;
        done         = 1'b0;
        cyc          = 0;

        while (!done) begin
            @(posedge g_clk);
            if (cyc == 0) begin
                check_value("fwd.rd", 128'(fwd.rd), 128'(s3_pkt.rd));
                check_value("fwd.wdata", 128'(fwd.wdata), 128'(s3_pkt.opr_a));
                check_value("fwd.load", 128'(fwd.load), 128'(case_mem[b+F_FWDL][0]));
                check_value("fwd.csr", 128'(fwd.csr), 128'(case_mem[b+F_FU][4]));
            end
            if (hold_lsu_req) begin
                check_value("dmem_req", 128'(dmem_req), 128'(1'b0)); // Held off
            end
            if (dmem_req) begin
                if (!exp_req) begin
                    fail_run($sformatf("Case %0d raised a request it must not make", c));
                end
                if (grants > 0) begin
                    fail_run($sformatf("Case %0d requested again after its grant", c));
                end
                if (!seen_req) begin
                    check_value("dmem.wen", 128'(dmem.wen), 128'(case_mem[b+F_WEN][0]));
                    check_value("dmem.strb", 128'(dmem.strb), 128'(case_mem[b+F_STRB][3:0]));
                    check_value("dmem.wdata", 128'(dmem.wdata), 128'(case_mem[b+F_WDATA]));
                    check_value("dmem.addr", 128'(dmem.addr), 128'(case_mem[b+F_ADDR]));
                    first_req = dmem;
                    seen_req  = 1'b1;
                end else begin
                    check_value("dmem", 128'(dmem), 128'(first_req)); // Stable
                end
                if (dmem_gnt) begin
                    grants++;
                end
            end
            if (s3_valid && !s3_busy) begin             // Progress
                exp_pkt_q.push_back(exp_pkt);
                exp_busy_q.push_back(pick_delay(case_mem[b+F_BUSY]));
                done = 1'b1;
            end
            cyc++;

            @(negedge g_clk);
            if (hold_left > 0) begin
                hold_left--;
            end
            hold_lsu_req = (hold_left > 0);
            dmem_gnt     = 1'b0;                        // One cycle pulse
            if (!done && seen_req && grants == 0) begin
                if (gnt_wait == 0) begin
                    dmem_gnt = 1'b1;
                end else begin
                    gnt_wait--;
                end
            end
        end
        check_value("grant count", 128'(grants), 128'(exp_req));
    endtask

    // ----------------------------------------------------------------------
    // Stage 4 side, stalls and in-order compare
    // ----------------------------------------------------------------------
    initial begin : stage4_sink
        s4_pkt_t held;
        bit      held_busy; // Last edge saw a stalled packet
        int      busy_left;
        bit      armed;     // Stall length loaded for this packet

        s4_busy   = 1'b0;
        held_busy = 1'b0;
        busy_left = 0;
        armed     = 1'b0;
        forever begin
            @(posedge g_clk);
            if (held_busy) begin
                check_value("s4_valid", 128'(s4_valid), 128'(1'b1));
                check_value("s4_pkt", 128'(s4_pkt), 128'(held)); // No change
            end
            held_busy = 1'b0;
            if (g_resetn && s4_valid) begin
                if (exp_pkt_q.size() == 0) begin
                    fail_run("Stage 4 received an instruction that was never accepted");
                end
                if (s4_busy) begin
                    held      = s4_pkt;
                    held_busy = 1'b1;
                end else begin
                    check_value("s4_pkt.rd", 128'(s4_pkt.rd), 128'(exp_pkt_q[0].rd));
                    check_value("s4_pkt.opr_a", 128'(s4_pkt.opr_a), 128'(exp_pkt_q[0].opr_a));
                    check_value("s4_pkt.opr_b", 128'(s4_pkt.opr_b), 128'(exp_pkt_q[0].opr_b));
                    check_value("s4_pkt.trap", 128'(s4_pkt.trap), 128'(exp_pkt_q[0].trap));
                    check_value("s4_pkt", 128'(s4_pkt), 128'(exp_pkt_q[0]));
                    void'(exp_pkt_q.pop_front());
                    void'(exp_busy_q.pop_front());
                    retired++;
                    armed = 1'b0;
                end
            end

            @(negedge g_clk);
            if (s4_valid && !armed && exp_busy_q.size() > 0) begin
                busy_left = exp_busy_q[0];
                armed     = 1'b1;
            end
            if (s4_valid && busy_left > 0) begin
                s4_busy = 1'b1;
                busy_left--;
            end else begin
                s4_busy = 1'b0;
            end
        end
    end

    // Watchdog, budget scales with the case count
    initial begin
        wait (loaded === 1'b1);
        repeat ((n_cases + 2) * CASE_CYC) @(posedge g_clk);
        fail_run("The run timed out before every case reached stage 4");
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int c;

        for (c = 0; c < N_FIELDS * MAX_CASES; c++) begin
            case_mem[c] = 32'h0;                        // Zero fu ends the list
        end
        g_resetn     = 1'b0;
        flush        = 1'b0;
        s3_pkt       = '0;
        s3_valid     = 1'b0;
        hold_lsu_req = 1'b0;
        dmem_gnt     = 1'b0;
        seed         = 37;
        retired      = 0;
        loaded       = 1'b0;

        $readmemh("test/mem_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[n_cases*N_FIELDS+F_FU] != 32'h0) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            fail_run("No cases could be read from test/mem_cases.txt");
        end
        loaded = 1'b1;

        repeat (10) @(negedge g_clk);
        g_resetn = 1'b1;

        for (c = 0; c < n_cases; c++) begin
            run_case(c);                                // Back to back
        end
        s3_valid     = 1'b0;
        hold_lsu_req = 1'b0;

        while (retired < n_cases) begin
            @(posedge g_clk);
        end
        @(negedge g_clk);
        if (exp_pkt_q.size() == 0 && retired == n_cases) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_run("Stage 4 did not receive every case exactly once");
        end
    end

endmodule

`default_nettype wire

/* test/mem_cases.txt */
// fu uop opr_a opr_b rd trap gnt_delay s4_busy hold, then expected req wen strb wdata addr
// and s4_rd s4_opr_a s4_opr_b s4_trap fwd_load; ff as a delay or busy means random 0..7
01 03 12345678 9abcdef0 05 0 0 0 0  0 0 0 0 0  05 12345678 9abcdef0 0 0
02 01 deadbeef 00000011 1f 0 0 2 0  0 0 0 0 0  1f deadbeef 00000011 0 0
10 05 00000300 00000008 0a 0 0 0 1  0 0 0 0 0  0a 00000300 00000008 0 0
04 02 80000000 80000004 01 1 0 0 0  0 0 0 0 0  01 80000000 80000004 1 0
08 12 00001003 000000a5 03 0 1 0 0  1 1 8 a5a5a5a5 00001000  03 8 00001003 0 0
08 12 00001000 1234563c 04 0 0 0 0  1 1 1 3c3c3c3c 00001000  04 1 00001000 0 0
08 12 00001001 00000077 06 0 2 0 0  1 1 2 77777777 00001000  06 2 00001001 0 0
08 12 00001002 000000e1 07 0 0 0 0  1 1 4 e1e1e1e1 00001000  07 4 00001002 0 0
08 14 00002000 1234beef 08 0 1 0 0  1 1 3 beefbeef 00002000  08 3 00002000 0 0
08 14 00002002 cafe5a5a 09 0 0 0 0  1 1 c 5a5a5a5a 00002000  09 c 00002002 0 0
08 16 00003000 0badf00d 0b 0 3 0 0  1 1 f 0badf00d 00003000  0b f 00003000 0 0
08 0b 00004001 00000000 0c 0 1 0 0  1 0 2 00000000 00004000  0c 2 00004001 0 1
08 0a 00004003 0000009a 0d 0 0 0 0  1 0 8 9a9a9a9a 00004000  0d 8 00004003 0 1
08 0d 00004002 00000000 0e 0 2 0 0  1 0 c 00000000 00004000  0e c 00004002 0 1
08 0c 00004000 11112222 0f 0 0 0 0  1 0 3 22222222 00004000  0f 3 00004000 0 1
08 0e 00005000 00000000 10 0 0 0 0  1 0 f 00000000 00005000  10 f 00005000 0 1
08 0e 00005004 00000000 11 0 5 0 3  1 0 f 00000000 00005004  11 f 00005004 0 1
08 16 00006008 89abcdef 12 0 0 0 4  1 1 f 89abcdef 00006008  12 f 00006008 0 0
08 14 0000600a 0000c3d2 13 0 ff ff 0  1 1 c c3d2c3d2 00006008  13 c 0000600a 0 0
08 0d 00004001 00000000 14 0 0 0 0  0 0 0 0 0  04 3 00004001 1 1
08 0e 00005002 00000000 15 0 0 0 0  0 0 0 0 0  04 f 00005002 1 1
08 14 00006003 00001111 16 0 0 0 0  0 0 0 0 0  06 c 00006003 1 0
08 16 00006001 00002222 17 0 0 1 0  0 0 0 0 0  06 f 00006001 1 0
08 16 00006002 00003333 18 0 0 0 2  0 0 0 0 0  06 f 00006002 1 0
08 0e 00007001 00000000 0e 1 0 0 0  0 0 0 0 0  0e f 00007001 1 1
01 00 00000042 00000024 19 0 0 5 0  0 0 0 0 0  19 00000042 00000024 0 0
08 16 00008000 a1b2c3d4 1a 0 0 3 0  1 1 f a1b2c3d4 00008000  1a f 00008000 0 0
08 0b 00008002 00000000 1b 0 1 ff 0  1 0 4 00000000 00008000  1b 4 00008002 0 1
08 12 00008007 000000c7 1c 0 ff ff 0  1 1 8 c7c7c7c7 00008004  1c 8 00008007 0 0
02 02 00000005 00000007 1d 0 0 ff 0  0 0 0 0 0  1d 00000005 00000007 0 0
10 01 00000340 00000001 1e 0 0 0 0  0 0 0 0 0  1e 00000340 00000001 0 0
08 0e 0000fffc 00000000 01 0 2 1 0  1 0 f 00000000 0000fffc  01 f 0000fffc 0 1

/* verilog.f */
+incdir+source
source/frv_pkg.sv
source/frv_lsu.sv
source/frv_pipeline_register.sv
source/frv_pipeline_memory.sv
test/tb_frv_pipeline_memory.sv

/* Makefile */
# Verilator build and run of the memory stage testbench

TOP := tb_frv_pipeline_memory
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  make clean  remove obj_dir and $(LOG)"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f verilog.f -o V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '** PASS **' $(LOG); then \
		echo "Result: test passed"; \
	else \
		echo "Result: test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
